/* lcdPkg.sv */
package lcdPkg;

  // One byte on the LCD bus, command or data
  typedef logic [7:0] lcdByteT;

  // Page 0 to 7, eight pixel rows each
  typedef logic [2:0] pageT;

  // Column over both chips, 0 to 127
  typedef logic [6:0] columnT;

  // Bit 0 drives CS1, bit 1 drives CS2
  typedef logic [1:0] chipSelT;

  // Controller command codes
  localparam lcdByteT CmdDisplayOn   = 8'h3F;
  localparam lcdByteT CmdStartColumn = 8'h40;  // Y address 0
  localparam lcdByteT CmdStartLine   = 8'hC0;  // Display start line 0
  localparam lcdByteT CmdPageBase    = 8'hB8;  // Low 3 bits carry the page

  // Geometry
  localparam int ChipColumns = 64;
  localparam int Pages       = 8;

endpackage

/* gamePkg.sv */
package gamePkg;

  // Symbol codes: 0 to 9 are digits
  typedef logic [3:0] symbolT;

  localparam symbolT SymPlus   = 4'hA;
  localparam symbolT SymMinus  = 4'hB;
  localparam symbolT SymTimes  = 4'hC;
  localparam symbolT SymDivide = 4'hD;
  localparam symbolT SymBlank  = 4'hE;  // F is blank as well

  // Index 2 is the leftmost symbol
  typedef symbolT [2:0] exprT;

  typedef logic [6:0] scoreT;
  typedef logic [2:0] livesT;

  // Status bar start columns
  localparam int StatusLetterL = 0;
  localparam int StatusLetterV = 8;
  localparam int StatusLevel   = 24;
  localparam int StatusHearts  = 80;

  localparam int LevelStep = 5;  // Score points per level
  localparam int MaxLevel  = 9;

  // Glyphs 0 to 13 follow the symbol codes
  typedef logic [4:0] glyphIdxT;

  localparam int       GlyphCount = 17;
  localparam glyphIdxT GlyphL     = 5'd14;
  localparam glyphIdxT GlyphV     = 5'd15;
  localparam glyphIdxT GlyphHeart = 5'd16;

  // Low byte to the even page, high byte to the odd page
  localparam logic [15:0] glyphFont [GlyphCount][8] = '{
    '{16'h0000, 16'h03E0, 16'h0C18, 16'h0808, 16'h0808, 16'h0C18, 16'h03E0, 16'h0000},  // 0
    '{16'h0000, 16'h0000, 16'h0810, 16'h0818, 16'h0FF8, 16'h0800, 16'h0800, 16'h0000},  // 1
    '{16'h0000, 16'h0000, 16'h0C10, 16'h0E08, 16'h0B08, 16'h0888, 16'h0870, 16'h0000},  // 2
    '{16'h0000, 16'h0000, 16'h0410, 16'h0888, 16'h0888, 16'h0888, 16'h0770, 16'h0000},  // 3
    '{16'h0000, 16'h0300, 16'h0280, 16'h0260, 16'h0218, 16'h0FF8, 16'h0200, 16'h0000},  // 4
    '{16'h0000, 16'h0000, 16'h0478, 16'h0848, 16'h0848, 16'h0CC8, 16'h0788, 16'h0000},  // 5
    '{16'h0000, 16'h03E0, 16'h0C90, 16'h0848, 16'h0848, 16'h0CC8, 16'h0700, 16'h0000},  // 6
    '{16'h0000, 16'h0000, 16'h0008, 16'h0C08, 16'h0388, 16'h0068, 16'h0018, 16'h0000},  // 7
    '{16'h0000, 16'h0000, 16'h0770, 16'h0888, 16'h0888, 16'h0888, 16'h0770, 16'h0000},  // 8
    '{16'h0000, 16'h0000, 16'h08F0, 16'h0908, 16'h0908, 16'h0518, 16'h03F0, 16'h0000},  // 9
    '{16'h0000, 16'h0180, 16'h0180, 16'h07E0, 16'h07E0, 16'h0180, 16'h0180, 16'h0000},  // Plus
    '{16'h0000, 16'h0180, 16'h0180, 16'h0180, 16'h0180, 16'h0180, 16'h0180, 16'h0000},  // Minus
    '{16'h0000, 16'h0420, 16'h0240, 16'h0180, 16'h0180, 16'h0240, 16'h0420, 16'h0000},  // Times
    '{16'h0000, 16'h0180, 16'h0180, 16'h05A0, 16'h05A0, 16'h0180, 16'h0180, 16'h0000},  // Divide
    '{16'h0010, 16'h0FF0, 16'h0FF0, 16'h0C10, 16'h0C00, 16'h0C00, 16'h0E00, 16'h0000},  // L
    '{16'h0020, 16'h00E0, 16'h03E0, 16'h0E00, 16'h0E00, 16'h03E0, 16'h00E0, 16'h0020},  // V
    '{16'h01C0, 16'h03E0, 16'h07F0, 16'h0FE0, 16'h0FE0, 16'h07F0, 16'h03E0, 16'h01C0}   // Heart
  };

endpackage

/* frameRenderer.sv */
`timescale 1ns/1ps

module frameRenderer (
  input  lcdPkg::pageT    page,
  input  lcdPkg::columnT  column,
  input  lcdPkg::columnT  position,
  input  gamePkg::exprT   expr0,
  input  gamePkg::exprT   expr1,
  input  gamePkg::exprT   expr2,
  input  gamePkg::scoreT  score,
  input  gamePkg::livesT  lives,
  output lcdPkg::lcdByteT pixelByte
);

  logic [4:0]        level;
  gamePkg::exprT     laneExpr;
  logic [7:0]        laneRel;
  gamePkg::symbolT   laneSym;
  gamePkg::glyphIdxT glyph;
  logic [2:0]        glyphCol;
  logic              glyphHit;
  logic [15:0]       fontColumn;

  // Level digit, saturating
  always_comb
  begin
    level = 5'(score / gamePkg::LevelStep) + 5'd1;
    if (level > gamePkg::MaxLevel)
      level = 5'(gamePkg::MaxLevel);
  end

  // Lane symbol under the current column
  always_comb
  begin
    case (page[2:1])
      2'd1:
        laneExpr = expr0;  // Pages 2 and 3
      2'd2:
        laneExpr = expr1;
      default:
        laneExpr = expr2;
    endcase
    laneRel = {1'b0, column} - {1'b0, position};
    laneSym = gamePkg::SymBlank;
    if (column >= position && laneRel < 8'd24)
      laneSym = laneExpr[2 - laneRel[4:3]];  // Leftmost symbol first
  end

  always_comb
  begin
    glyph    = gamePkg::GlyphHeart;
    glyphCol = column[2:0];  // Status glyphs start on 8-column bounds
    glyphHit = 1'b0;
    if (page[2:1] == 2'd0)
    begin
      if (column >= gamePkg::StatusLetterL && column < gamePkg::StatusLetterL + 8)
      begin
        glyph    = gamePkg::GlyphL;
        glyphHit = 1'b1;
      end
      else if (column >= gamePkg::StatusLetterV && column < gamePkg::StatusLetterV + 8)
      begin
        glyph    = gamePkg::GlyphV;
        glyphHit = 1'b1;
      end
      else if (column >= gamePkg::StatusLevel && column < gamePkg::StatusLevel + 8)
      begin
        glyph    = level;
        glyphHit = 1'b1;
      end
      else if (column >= gamePkg::StatusHearts &&
               column < gamePkg::StatusHearts + 8 * lives)
      begin
        glyph    = gamePkg::GlyphHeart;  // One per remaining life
        glyphHit = 1'b1;
      end
    end
    else if (laneSym <= gamePkg::SymDivide)
    begin
      glyph    = {1'b0, laneSym};
      glyphCol = laneRel[2:0];
      glyphHit = 1'b1;
    end
  end

  assign fontColumn = gamePkg::glyphFont[glyph][glyphCol];

  // Even page takes the top half of the glyph
  assign pixelByte = !glyphHit ? 8'h00 :
                     page[0]   ? fontColumn[15:8] : fontColumn[7:0];

endmodule

/* lcdSequencer.sv */
`timescale 1ns/1ps

module lcdSequencer #(
  parameter int DividerBits = 8,
  parameter int FrameGap    = 16
) (
  input  logic            CLK,
  input  logic            RESET,
  input  lcdPkg::lcdByteT pixelByte,
  output lcdPkg::pageT    page,
  output lcdPkg::columnT  column,
  output logic            frameDone,
  output logic            LCD_ENABLE,
  output logic            LCD_RW,
  output logic            LCD_DI,
  output logic            LCD_CS1,
  output logic            LCD_CS2,
  output logic            LCD_RST,
  output lcdPkg::lcdByteT LCD_DATA
);

  localparam int StartupTicks = 16;
  localparam int WaitMax      = (StartupTicks > FrameGap) ? StartupTicks : FrameGap;
  localparam int WaitBits     = $clog2(WaitMax + 1);

  localparam lcdPkg::columnT ChipColumnsLast = lcdPkg::columnT'(lcdPkg::ChipColumns - 1);

  typedef enum logic [2:0] {
    StDelay,
    StInit,
    StClearCmd,
    StClearData,
    StPageCmd,
    StPageData,
    StGap
  } stateT;

  stateT                  state;
  logic [DividerBits-1:0] divider;
  logic                   tick;
  logic [1:0]             phase;
  logic                   slot;
  logic [1:0]             initIndex;
  logic [WaitBits-1:0]    waitCount;
  lcdPkg::chipSelT        chipSel;
  logic                   sending;
  logic                   sendData;
  lcdPkg::chipSelT        sendSel;
  lcdPkg::lcdByteT        sendByte;

  assign tick = &divider;            // One LCD tick per divider wrap
  assign slot = tick && (phase == 2'd0);

  // What the current state puts on the bus
  always_comb
  begin
    sending  = 1'b1;
    sendData = 1'b0;
    sendSel  = 2'b11;
    sendByte = 8'h00;
    case (state)
      StInit:
        case (initIndex)
          2'd0:
            sendByte = lcdPkg::CmdDisplayOn;
          2'd1:
            sendByte = lcdPkg::CmdStartColumn;
          default:
            sendByte = lcdPkg::CmdStartLine;
        endcase
      StClearCmd, StPageCmd:
        sendByte = lcdPkg::CmdPageBase | lcdPkg::lcdByteT'(page);
      StClearData:
        sendData = 1'b1;
      StPageData:
      begin
        sendData = 1'b1;
        sendSel  = column[6] ? 2'b10 : 2'b01;  // Right half on chip 2
        sendByte = pixelByte;
      end
      default:
        sending = 1'b0;
    endcase
  end

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      divider    <= '0;
      state      <= StDelay;
      phase      <= 2'd0;
      initIndex  <= 2'd0;
      waitCount  <= '0;
      page       <= '0;
      column     <= '0;
      frameDone  <= 1'b0;
      LCD_ENABLE <= 1'b0;
      LCD_DI     <= 1'b0;
      LCD_RST    <= 1'b0;
      chipSel    <= 2'b11;
    end
    else
    begin
      divider   <= divider + 1'b1;
      frameDone <= 1'b0;
      if (tick)
      begin
        case (phase)
          2'd1:
          begin
            LCD_ENABLE <= 1'b1;
            phase      <= 2'd2;
          end
          2'd2:
          begin
            LCD_ENABLE <= 1'b0;
            phase      <= 2'd0;
          end
          default:
          begin
            if (sending)
            begin
              phase   <= 2'd1;
              LCD_DI  <= sendData;
              chipSel <= sendSel;
            end
            case (state)
              StDelay:
                if (waitCount == WaitBits'(StartupTicks - 1))
                begin
                  LCD_RST   <= 1'b1;
                  waitCount <= '0;
                  state     <= StInit;
                end
                else
                  waitCount <= waitCount + 1'b1;
              StInit:
              begin
                initIndex <= initIndex + 1'b1;
                if (initIndex == 2'd2)
                  state <= StClearCmd;
              end
              StClearCmd, StPageCmd:
              begin
                column <= '0;
                state  <= (state == StClearCmd) ? StClearData : StPageData;
              end
              StClearData:
                if (column == ChipColumnsLast)
                begin
                  page  <= page + 1'b1;
                  state <= (page == lcdPkg::Pages - 1) ? StPageCmd : StClearCmd;
                end
                else
                  column <= column + 1'b1;
              StPageData:
              begin
                column <= column + 1'b1;
                if (column == lcdPkg::columnT'(2 * lcdPkg::ChipColumns - 1))
                begin
                  page  <= page + 1'b1;   // Wraps to page 0 after the frame
                  state <= (page == lcdPkg::Pages - 1) ? StGap : StPageCmd;
                end
              end
              default:
              begin
                frameDone <= (waitCount == '0);  // First gap tick only
                if (waitCount == WaitBits'(FrameGap - 1))
                begin
                  waitCount <= '0;
                  state     <= StPageCmd;
                end
                else
                  waitCount <= waitCount + 1'b1;
              end
            endcase
          end
        endcase
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (slot && sending)
      LCD_DATA <= sendByte;
  end

  assign LCD_RW  = 1'b0;  // Write only
  assign LCD_CS1 = chipSel[0];
  assign LCD_CS2 = chipSel[1];

endmodule

/* scrollTracker.sv */
`timescale 1ns/1ps

module scrollTracker #(
  parameter int FramesPerStep = 4,
  parameter int WrapColumn    = 64
) (
  input  logic           CLK,
  input  logic           RESET,
  input  logic           frameDone,
  output lcdPkg::columnT position,
  output logic           update
);

  localparam int FrameBits = $clog2(FramesPerStep + 1);

  logic [FrameBits-1:0] frameCount;
  logic                 step;

  assign step = frameDone && (frameCount == FrameBits'(FramesPerStep - 1));

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      frameCount <= '0;
      position   <= '0;
      update     <= 1'b0;
    end
    else
    begin
      update <= 1'b0;
      if (frameDone)
        frameCount <= step ? '0 : frameCount + 1'b1;
      if (step)
      begin
        if (position == lcdPkg::columnT'(WrapColumn - 1))
        begin
          position <= '0;
          update   <= 1'b1;  // Ask for new expressions
        end
        else
          position <= position + 1'b1;
      end
    end
  end

endmodule

/* gameDisplay.sv */
`timescale 1ns/1ps

module gameDisplay #(
  parameter int DividerBits   = 8,
  parameter int FramesPerStep = 4,
  parameter int WrapColumn    = 64,
  parameter int FrameGap      = 16
) (
  input  logic            CLK,
  input  logic            RESET,
  input  gamePkg::exprT   expr0,
  input  gamePkg::exprT   expr1,
  input  gamePkg::exprT   expr2,
  input  gamePkg::scoreT  score,
  input  gamePkg::livesT  lives,
  output logic            LCD_ENABLE,
  output logic            LCD_RW,
  output logic            LCD_DI,
  output logic            LCD_CS1,
  output logic            LCD_CS2,
  output logic            LCD_RST,
  output lcdPkg::lcdByteT LCD_DATA,
  output logic            update
);

  lcdPkg::pageT    page;
  lcdPkg::columnT  column;
  lcdPkg::columnT  position;
  lcdPkg::lcdByteT pixelByte;
  logic            frameDone;

  lcdSequencer #(
    .DividerBits (DividerBits),
    .FrameGap    (FrameGap)
  ) sequencer_i (
    .CLK        (CLK),
    .RESET      (RESET),
    .pixelByte  (pixelByte),
    .page       (page),
    .column     (column),
    .frameDone  (frameDone),
    .LCD_ENABLE (LCD_ENABLE),
    .LCD_RW     (LCD_RW),
    .LCD_DI     (LCD_DI),
    .LCD_CS1    (LCD_CS1),
    .LCD_CS2    (LCD_CS2),
    .LCD_RST    (LCD_RST),
    .LCD_DATA   (LCD_DATA)
  );

  frameRenderer renderer_i (
    .page      (page),
    .column    (column),
    .position  (position),
    .expr0     (expr0),
    .expr1     (expr1),
    .expr2     (expr2),
    .score     (score),
    .lives     (lives),
    .pixelByte (pixelByte)
  );

  scrollTracker #(
    .FramesPerStep (FramesPerStep),
    .WrapColumn    (WrapColumn)
  ) tracker_i (
    .CLK       (CLK),
    .RESET     (RESET),
    .frameDone (frameDone),
    .position  (position),
    .update    (update)
  );

endmodule

/* tbReference.svh */
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// Start-up commands in the order they go out
function automatic lcdPkg::lcdByteT refInitByte(input int index);
  if (index == 0)
    return 8'h3F;
  else if (index == 1)
    return 8'h40;
  return 8'hC0;
endfunction

function automatic lcdPkg::lcdByteT refGlyphByte(input int glyph, input int col, input int page);
  logic [15:0] bits;
  bits = gamePkg::glyphFont[glyph][col];
  return (page % 2 == 1) ? bits[15:8] : bits[7:0];  // Odd page shows the lower half
endfunction

function automatic int refLevel(input int score);
  int level;
  level = score / gamePkg::LevelStep + 1;
  if (level > gamePkg::MaxLevel)
    level = gamePkg::MaxLevel;
  return level;
endfunction

function automatic lcdPkg::lcdByteT refStatusByte(input int page, input int column,
                                                  input int score, input int lives);
  if (column >= gamePkg::StatusLetterL && column < gamePkg::StatusLetterL + 8)
    return refGlyphByte(gamePkg::GlyphL, column - gamePkg::StatusLetterL, page);
  if (column >= gamePkg::StatusLetterV && column < gamePkg::StatusLetterV + 8)
    return refGlyphByte(gamePkg::GlyphV, column - gamePkg::StatusLetterV, page);
  if (column >= gamePkg::StatusLevel && column < gamePkg::StatusLevel + 8)
    return refGlyphByte(refLevel(score), column - gamePkg::StatusLevel, page);
  if (column >= gamePkg::StatusHearts && column < gamePkg::StatusHearts + 8 * lives)
    return refGlyphByte(gamePkg::GlyphHeart, (column - gamePkg::StatusHearts) % 8, page);
  return 8'h00;
endfunction

function automatic lcdPkg::lcdByteT refLaneByte(input int page, input int column,
                                                input int position, input logic [11:0] e0,
                                                input logic [11:0] e1, input logic [11:0] e2);
  logic [11:0] expr;
  int          offset;
  int          symbol;
  expr = e2;
  if ((page - 2) / 2 == 0)
    expr = e0;
  else if ((page - 2) / 2 == 1)
    expr = e1;
  offset = column - position;
  if (offset < 0 || offset >= 24)
    return 8'h00;
  symbol = (expr >> (4 * (2 - offset / 8))) & 'hF;  // First symbol is the top nibble
  if (symbol > 13)
    return 8'h00;  // E and F stay blank
  return refGlyphByte(symbol, offset % 8, page);
endfunction

function automatic lcdPkg::lcdByteT refPixel(input int page, input int column,
                                             input int position, input logic [11:0] e0,
                                             input logic [11:0] e1, input logic [11:0] e2,
                                             input int score, input int lives);
  if (page < 2)
    return refStatusByte(page, column, score, lives);
  return refLaneByte(page, column, position, e0, e1, e2);
endfunction

`endif

/* tbGameDisplay.sv */
`timescale 1ns/1ps

module tbGameDisplay;

  localparam int DividerBits   = 2;
  localparam int FramesPerStep = 1;
  localparam int WrapColumn    = 8;
  localparam int FrameGap      = 4;
  localparam int NumFrames     = 17;  // Two wraps, each followed by a frame at column 0
  localparam int Seed          = 72066;
  localparam int TickCycles    = 1 << DividerBits;
  localparam int StartupTicks  = 16;
  localparam int ClearEnd      = 3 + 8 * 65;  // Transfers before the first frame
  localparam int FrameTicks    = 8 * 129 * 3 + FrameGap;
  localparam int TimeoutCycles = 10 + (StartupTicks + ClearEnd * 3) * TickCycles
                                 + (NumFrames + 1) * FrameTicks * TickCycles;

  logic            CLK = 1'b0;
  logic            RESET;
  gamePkg::exprT   expr0;
  gamePkg::exprT   expr1;
  gamePkg::exprT   expr2;
  gamePkg::scoreT  score;
  gamePkg::livesT  lives;
  logic            LCD_ENABLE;
  logic            LCD_RW;
  logic            LCD_DI;
  logic            LCD_CS1;
  logic            LCD_CS2;
  logic            LCD_RST;
  lcdPkg::lcdByteT LCD_DATA;
  logic            update;

  int   byteErrors = 0;
  int   selectErrors = 0;
  int   levelErrors = 0;
  int   otherErrors = 0;
  int   transferCount = 0;
  int   decPage = 0;
  int   decColumn = 0;
  int   pageLength = 0;
  int   nextPage = 0;
  int   position = 0;
  int   framesSinceStep = 0;
  int   framesStarted = 0;
  int   updateCycles = 0;
  int   round = 0;
  logic done = 1'b0;

  `include "tbReference.svh"

  gameDisplay #(
    .DividerBits   (DividerBits),
    .FramesPerStep (FramesPerStep),
    .WrapColumn    (WrapColumn),
    .FrameGap      (FrameGap)
  ) dut_i (
    .CLK        (CLK),
    .RESET      (RESET),
    .expr0      (expr0),
    .expr1      (expr1),
    .expr2      (expr2),
    .score      (score),
    .lives      (lives),
    .LCD_ENABLE (LCD_ENABLE),
    .LCD_RW     (LCD_RW),
    .LCD_DI     (LCD_DI),
    .LCD_CS1    (LCD_CS1),
    .LCD_CS2    (LCD_CS2),
    .LCD_RST    (LCD_RST),
    .LCD_DATA   (LCD_DATA),
    .update     (update)
  );

  always #10 CLK = ~CLK;

  task automatic checkByte(input string name, input lcdPkg::lcdByteT actual,
                           input lcdPkg::lcdByteT expected);
    if (actual !== expected)
    begin
      byteErrors++;
      $display("error at %0t: %s expected %h, got %h (page %0d, column %0d)",
               $time, name, expected, actual, decPage, decColumn);
    end
  endtask

  task automatic checkSelect(input lcdPkg::chipSelT actual, input lcdPkg::chipSelT expected);
    if (actual !== expected)
    begin
      selectErrors++;
      $display("error at %0t: {LCD_CS2, LCD_CS1} expected %b, got %b (page %0d, column %0d)",
               $time, expected, actual, decPage, decColumn);
    end
  endtask

  task automatic checkPulse(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      levelErrors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic printCounts();
    $display("byte errors %0d, select errors %0d, level errors %0d, other failures %0d",
             byteErrors, selectErrors, levelErrors, otherErrors);
  endtask

  task automatic loadInputs(input int which);
    expr0 = gamePkg::exprT'($urandom);
    expr1 = gamePkg::exprT'($urandom);
    expr2 = gamePkg::exprT'($urandom);
    score = gamePkg::scoreT'($urandom);
    lives = gamePkg::livesT'($urandom);
    if (which == 0)
    begin
      score = 7'd127;  // Level cap, no hearts
      lives = 3'd0;
    end
    else if (which == 1)
    begin
      score = gamePkg::scoreT'($urandom % 40);  // Level below the cap
      lives = gamePkg::livesT'(1 + $urandom % 7);
    end
  endtask

  // Page-0 command marks the frame boundary
  task automatic startFrame();
    logic wrapExpected;
    wrapExpected = 1'b0;
    if (framesStarted > 0)
    begin
      framesSinceStep++;
      if (framesSinceStep == FramesPerStep)
      begin
        framesSinceStep = 0;
        wrapExpected    = (position == WrapColumn - 1);
        position        = wrapExpected ? 0 : position + 1;
      end
    end
    if (updateCycles > 1)
    begin
      otherErrors++;
      $display("update stayed high for %0d cycles instead of one", updateCycles);
    end
    checkPulse("update", updateCycles != 0, wrapExpected);
    updateCycles = 0;
    if (framesStarted == NumFrames)
      done = 1'b1;
    framesStarted++;
  endtask

  always @(posedge LCD_ENABLE)
  begin : busDecoder
    lcdPkg::chipSelT sel;
    logic            clearing;
    sel      = {LCD_CS2, LCD_CS1};
    clearing = transferCount < ClearEnd;
    checkPulse("LCD_RW", LCD_RW, 1'b0);
    if (transferCount < 3)
    begin
      checkPulse("LCD_RST", LCD_RST, 1'b1);  // Must already be released
      checkPulse("LCD_DI", LCD_DI, 1'b0);
      checkSelect(sel, 2'b11);
      checkByte("LCD_DATA", LCD_DATA, refInitByte(transferCount));
    end
    else if (!LCD_DI)
    begin
      checkSelect(sel, 2'b11);
      checkByte("LCD_DATA", LCD_DATA, 8'hB8 | lcdPkg::lcdByteT'(nextPage));
      if (transferCount > 3 && decColumn != pageLength)
      begin
        otherErrors++;
        $display("page %0d ended after %0d data bytes instead of %0d",
                 decPage, decColumn, pageLength);
      end
      decPage    = LCD_DATA[2:0];
      decColumn  = 0;
      pageLength = clearing ? 64 : 128;
      nextPage   = (nextPage + 1) % 8;
      if (!clearing && decPage == 0)
        startFrame();
    end
    else if (decColumn >= pageLength)
    begin
      otherErrors++;
      $display("data byte sent past the last column of page %0d", decPage);
    end
    else
    begin
      if (clearing)
      begin
        checkSelect(sel, 2'b11);
        checkByte("LCD_DATA", LCD_DATA, 8'h00);
      end
      else
      begin
        checkSelect(sel, (decColumn < 64) ? 2'b01 : 2'b10);
        checkByte("LCD_DATA", LCD_DATA,
                  refPixel(decPage, decColumn, position, expr0, expr1, expr2, score, lives));
      end
      decColumn++;
    end
    transferCount++;
  end

  initial
  begin : stimulus
    int unused;
    unused = $urandom(Seed);
    RESET  = 1'b0;
    loadInputs(round);
    repeat (10) @(negedge CLK);
    checkPulse("LCD_ENABLE", LCD_ENABLE, 1'b0);
    checkPulse("LCD_RST", LCD_RST, 1'b0);
    checkPulse("LCD_DI", LCD_DI, 1'b0);
    checkSelect({LCD_CS2, LCD_CS1}, 2'b11);
    checkPulse("update", update, 1'b0);
    RESET = 1'b1;
    @(negedge CLK);
    checkPulse("LCD_ENABLE", LCD_ENABLE, 1'b0);
    checkPulse("update", update, 1'b0);
    while (!done)
    begin
      @(negedge CLK);
      if (update)
      begin
        updateCycles++;
        round++;
        loadInputs(round);  // New expressions for the frame at column 0
      end
    end
    printCounts();
    if (byteErrors + selectErrors + levelErrors + otherErrors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles)
    begin
      @(posedge CLK);
      cycles++;
    end
    otherErrors++;
    $display("timeout after %0d cycles with %0d of %0d frames started",
             cycles, framesStarted, NumFrames);
    printCounts();
    $display("tests failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
lcdPkg.sv
gamePkg.sv
frameRenderer.sv
lcdSequencer.sv
scrollTracker.sv
gameDisplay.sv
tbGameDisplay.sv

/* Bender.yml */
package:
  name: gameDisplay

sources:
  - lcdPkg.sv
  - gamePkg.sv
  - frameRenderer.sv
  - lcdSequencer.sv
  - scrollTracker.sv
  - gameDisplay.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbGameDisplay.sv
